//--- rtl/burst_ctrl_settings.svh
`ifndef BURST_CTRL_SETTINGS_SVH
`define BURST_CTRL_SETTINGS_SVH

////////////////////////////////////////////////////////////
// data path widths
////////////////////////////////////////////////////////////
`define BC_USER_WIDTH      32  // user stream word
`define BC_AXI_WIDTH       64  // one axi beat, two user words
`define BC_ADDR_WIDTH      30  // byte address
`define BC_LEN_WIDTH       8   // axi burst length, beats minus one

////////////////////////////////////////////////////////////
// buffering
////////////////////////////////////////////////////////////
`define BC_FIFO_DEPTH      64  // axi words per fifo, power of two
`define BC_FIFO_CNT_WIDTH  7   // holds 0 .. BC_FIFO_DEPTH
`define BC_RD_LOW_WATER    32  // read refill threshold in axi words
`define BC_BYTES_PER_BEAT  8   // BC_AXI_WIDTH / 8

`endif

//--- rtl/burst_ctrl_pkg.sv
`default_nettype none

`include "burst_ctrl_settings.svh"

package burst_ctrl_pkg;

    // payload words on both sides of the width converters
    typedef logic [`BC_USER_WIDTH-1:0]     user_word_t;  // user port word
    typedef logic [`BC_AXI_WIDTH-1:0]      axi_word_t;   // axi data beat

    // burst bookkeeping
    typedef logic [`BC_ADDR_WIDTH-1:0]     mem_addr_t;   // byte address
    typedef logic [`BC_LEN_WIDTH-1:0]      burst_len_t;  // beats minus one
    typedef logic [`BC_FIFO_CNT_WIDTH-1:0] fifo_cnt_t;   // fifo fill level

endpackage

`default_nettype wire

//--- rtl/burst_fifo.sv
`default_nettype none

`include "burst_ctrl_settings.svh"

// first-word-fall-through buffer of axi words, single clock
module burst_fifo (
    input  logic                      clk,
    input  logic                      rst_n_sync,
    input  logic                      push,       // write strobe
    input  burst_ctrl_pkg::axi_word_t push_data,
    input  logic                      pop,        // consume head
    output burst_ctrl_pkg::axi_word_t head_data,  // oldest word, no read latency
    output logic                      empty,
    output burst_ctrl_pkg::fifo_cnt_t count       // occupancy in axi words
);
    import burst_ctrl_pkg::*;

    localparam int PTR_W = $clog2(`BC_FIFO_DEPTH);  // pointer wraps on its own

    axi_word_t        mem [`BC_FIFO_DEPTH];  // storage array
    logic [PTR_W-1:0] wr_ptr;                // next free slot
    logic [PTR_W-1:0] rd_ptr;                // current head slot
    logic             full;
    logic             push_ok;               // push that is accepted
    logic             pop_ok;                // pop that is accepted

    ////////////////////////////////////////////////////////////
    // status
    ////////////////////////////////////////////////////////////
    assign full    = (count == fifo_cnt_t'(`BC_FIFO_DEPTH));
    assign empty   = (count == '0);
    assign push_ok = push && !full;  // push into full fifo is lost
    assign pop_ok  = pop && !empty;  // pop of empty fifo does nothing

    assign head_data = mem[rd_ptr];  // fall-through head

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;  // visible at head next cycle
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers and count
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;  // pop lands on this edge
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;  // push only
                2'b01:   count <= count - 1'b1;  // pop only
                default: count <= count;         // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/word_packer.sv
`default_nettype none

`include "burst_ctrl_settings.svh"

// joins two user words into one axi word, earlier word low
module word_packer (
    input  logic                       clk,
    input  logic                       rst_n_sync,
    input  logic                       wr_en,      // user write strobe
    input  burst_ctrl_pkg::user_word_t wr_data,
    output logic                       push,       // one cycle per completed pair
    output burst_ctrl_pkg::axi_word_t  push_data   // {later, earlier}
);
    import burst_ctrl_pkg::*;

    user_word_t low_word;  // first word of the pair
    logic       phase;     // 1 = low half already held

    ////////////////////////////////////////////////////////////
    // pair assembly
    ////////////////////////////////////////////////////////////
    assign push      = wr_en && phase;        // second word completes pair
    assign push_data = {wr_data, low_word};   // fifo takes it at next edge

    always_ff @(posedge clk) begin
        if (wr_en && !phase) begin
            low_word <= wr_data;  // park first word
        end
    end

    always_ff @(posedge clk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            phase <= 1'b0;  // start with empty pair
        end else if (wr_en) begin
            phase <= !phase;
        end
    end

endmodule

`default_nettype wire

//--- rtl/word_unpacker.sv
`default_nettype none

`include "burst_ctrl_settings.svh"

// splits axi words from the read fifo into user words, low half first
module word_unpacker (
    input  logic                       clk,
    input  logic                       rst_n_sync,
    input  logic                       fifo_empty,  // read fifo has nothing
    input  burst_ctrl_pkg::axi_word_t  head_data,   // read fifo head
    output logic                       pop,         // take the head this edge
    input  logic                       rd_en,       // user consumes rd_data
    output burst_ctrl_pkg::user_word_t rd_data,
    output logic                       rd_valid
);
    import burst_ctrl_pkg::*;

    axi_word_t held;     // word being handed out
    logic      have;     // held word not yet used up
    logic      hi_sel;   // 0 = low half showing, 1 = high half
    logic      consume;  // accepted user read

    assign consume  = rd_en && have;  // read without data is ignored
    assign rd_valid = have;

    // refill when idle or when the last half goes out
    assign pop = !fifo_empty && (!have || (consume && hi_sel));

    assign rd_data = hi_sel ? held[`BC_AXI_WIDTH-1:`BC_USER_WIDTH]
                            : held[`BC_USER_WIDTH-1:0];

    ////////////////////////////////////////////////////////////
    // holding register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (pop) begin
            held <= head_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            have   <= 1'b0;
            hi_sel <= 1'b0;
        end else if (pop) begin
            have   <= 1'b1;  // fresh word, low half first
            hi_sel <= 1'b0;
        end else if (consume) begin
            if (hi_sel) begin
                have   <= 1'b0;  // drained, fifo was empty
                hi_sel <= 1'b0;
            end else begin
                hi_sel <= 1'b1;  // high half next cycle
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/burst_addr_gen.sv
`default_nettype none

`include "burst_ctrl_settings.svh"

// start address of the next burst, steps per burst and wraps in a window
module burst_addr_gen (
    input  logic                       clk,
    input  logic                       rst_n_sync,
    input  logic                       reload,     // user reset pulse
    input  logic                       done,       // burst finished pulse
    input  burst_ctrl_pkg::mem_addr_t  beg_addr,   // window start
    input  burst_ctrl_pkg::mem_addr_t  end_addr,   // window end
    input  burst_ctrl_pkg::burst_len_t burst_len,  // beats minus one
    output burst_ctrl_pkg::mem_addr_t  addr
);
    import burst_ctrl_pkg::*;

    mem_addr_t incr;   // bytes in one burst
    mem_addr_t limit;  // last address that still leaves room
    logic      wrap;

    ////////////////////////////////////////////////////////////
    // step and wrap check
    ////////////////////////////////////////////////////////////
    assign incr = (mem_addr_t'(burst_len) + mem_addr_t'(1))
                * mem_addr_t'(`BC_BYTES_PER_BEAT);

    // another burst after the next one would pass end_addr
    assign limit = end_addr - (incr << 1) + mem_addr_t'(1);
    assign wrap  = (addr > limit);

    always_ff @(posedge clk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            addr <= beg_addr;  // window start out of reset
        end else if (reload) begin
            addr <= beg_addr;
        end else if (done) begin
            if (wrap) begin
                addr <= beg_addr;  // back to window start
            end else begin
                addr <= addr + incr;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/burst_request.sv
`default_nettype none

`include "burst_ctrl_settings.svh"

// start requests toward the axi write and read masters
module burst_request (
    input  logic                       clk,
    input  logic                       rst_n_sync,
    input  burst_ctrl_pkg::fifo_cnt_t  wr_count,       // write fifo fill
    input  burst_ctrl_pkg::fifo_cnt_t  rd_count,       // read fifo fill
    input  burst_ctrl_pkg::burst_len_t wr_burst_len,
    input  burst_ctrl_pkg::burst_len_t rd_burst_len,
    input  logic                       axi_wr_ready,   // write master idle
    input  logic                       axi_rd_ready,   // read master idle
    input  logic                       rd_mem_enable,  // memory holds data worth reading
    output logic                       axi_wr_start,
    output logic                       axi_rd_start
);
    import burst_ctrl_pkg::*;

    localparam int EXT_W = `BC_LEN_WIDTH + 1;  // room for len + 1

    logic [EXT_W-1:0] wr_beats;  // beats in one write burst
    logic [EXT_W-1:0] rd_beats;  // beats in one read burst
    logic             wr_enough;
    logic             rd_low;
    logic             rd_room;

    assign wr_beats = EXT_W'(wr_burst_len) + EXT_W'(1);
    assign rd_beats = EXT_W'(rd_burst_len) + EXT_W'(1);

    assign wr_enough = (EXT_W'(wr_count) > wr_beats);  // more than one burst queued
    assign rd_low    = (rd_count < fifo_cnt_t'(`BC_RD_LOW_WATER));
    // burst must still fit in the read fifo
    assign rd_room   = ((EXT_W + 1)'(rd_count) + (EXT_W + 1)'(rd_beats))
                     <= (EXT_W + 1)'(`BC_FIFO_DEPTH);

    ////////////////////////////////////////////////////////////
    // start flags, dropped once the master goes busy
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            axi_wr_start <= 1'b0;
            axi_rd_start <= 1'b0;
        end else begin
            if (!axi_wr_ready) begin
                axi_wr_start <= 1'b0;  // master took the request
            end else if (wr_enough) begin
                axi_wr_start <= 1'b1;
            end
            if (!axi_rd_ready) begin
                axi_rd_start <= 1'b0;
            end else if (rd_mem_enable && rd_low && rd_room) begin
                axi_rd_start <= 1'b1;  // refill below low water
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/axi_burst_ctrl.sv
`default_nettype none

`include "burst_ctrl_settings.svh"

// burst controller between the user stream port and an axi read/write master
module axi_burst_ctrl (
    input  logic                       clk,
    input  logic                       rst_n_sync,
    // user write side
    input  logic                       wr_rst,        // reload write address
    input  logic                       rd_rst,        // reload read address
    input  logic                       wr_en,
    input  burst_ctrl_pkg::user_word_t wr_data,
    input  burst_ctrl_pkg::mem_addr_t  wr_beg_addr,
    input  burst_ctrl_pkg::mem_addr_t  wr_end_addr,
    input  burst_ctrl_pkg::mem_addr_t  rd_beg_addr,
    input  burst_ctrl_pkg::mem_addr_t  rd_end_addr,
    input  burst_ctrl_pkg::burst_len_t wr_burst_len,
    input  burst_ctrl_pkg::burst_len_t rd_burst_len,
    // user read side
    input  logic                       rd_mem_enable,
    input  logic                       rd_en,
    output burst_ctrl_pkg::user_word_t rd_data,
    output logic                       rd_valid,
    // axi write master
    input  logic                       axi_writing,   // one beat taken per cycle
    input  logic                       axi_wr_ready,
    input  logic                       axi_wr_done,
    output logic                       axi_wr_start,
    output burst_ctrl_pkg::axi_word_t  axi_wr_data,
    output burst_ctrl_pkg::mem_addr_t  axi_wr_addr,
    output burst_ctrl_pkg::burst_len_t axi_wr_len,
    // axi read master
    input  logic                       axi_reading,   // one beat delivered per cycle
    input  logic                       axi_rd_ready,
    input  logic                       axi_rd_done,
    input  burst_ctrl_pkg::axi_word_t  axi_rd_data,
    output logic                       axi_rd_start,
    output burst_ctrl_pkg::mem_addr_t  axi_rd_addr,
    output burst_ctrl_pkg::burst_len_t axi_rd_len
);

    logic                              pack_push;   // packer to write fifo
    burst_ctrl_pkg::axi_word_t         pack_data;
    logic [`BC_FIFO_CNT_WIDTH-1:0]     wr_count;    // write fifo fill
    logic [`BC_FIFO_CNT_WIDTH-1:0]     rd_count;    // read fifo fill
    burst_ctrl_pkg::axi_word_t         rd_head;     // read fifo to unpacker
    logic                              rd_empty;
    logic                              rd_pop;

    assign axi_wr_len = wr_burst_len;  // no trimming at window end
    assign axi_rd_len = rd_burst_len;

    ////////////////////////////////////////////////////////////
    // write path
    ////////////////////////////////////////////////////////////
    word_packer u_word_packer (
        .clk        (clk),
        .rst_n_sync (rst_n_sync),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .push       (pack_push),
        .push_data  (pack_data)
    );

    burst_fifo wr_fifo (
        .clk        (clk),
        .rst_n_sync (rst_n_sync),
        .push       (pack_push),
        .push_data  (pack_data),
        .pop        (axi_writing),   // drained while master writes
        .head_data  (axi_wr_data),
        .empty      (),
        .count      (wr_count)
    );

    ////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////
    burst_fifo rd_fifo (
        .clk        (clk),
        .rst_n_sync (rst_n_sync),
        .push       (axi_reading),   // captured while master reads
        .push_data  (axi_rd_data),
        .pop        (rd_pop),
        .head_data  (rd_head),
        .empty      (rd_empty),
        .count      (rd_count)
    );

    word_unpacker u_word_unpacker (
        .clk        (clk),
        .rst_n_sync (rst_n_sync),
        .fifo_empty (rd_empty),
        .head_data  (rd_head),
        .pop        (rd_pop),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    ////////////////////////////////////////////////////////////
    // requests and addresses
    ////////////////////////////////////////////////////////////
    burst_request u_burst_request (
        .clk           (clk),
        .rst_n_sync    (rst_n_sync),
        .wr_count      (wr_count),
        .rd_count      (rd_count),
        .wr_burst_len  (wr_burst_len),
        .rd_burst_len  (rd_burst_len),
        .axi_wr_ready  (axi_wr_ready),
        .axi_rd_ready  (axi_rd_ready),
        .rd_mem_enable (rd_mem_enable),
        .axi_wr_start  (axi_wr_start),
        .axi_rd_start  (axi_rd_start)
    );

    burst_addr_gen wr_addr_gen (
        .clk        (clk),
        .rst_n_sync (rst_n_sync),
        .reload     (wr_rst),
        .done       (axi_wr_done),
        .beg_addr   (wr_beg_addr),
        .end_addr   (wr_end_addr),
        .burst_len  (wr_burst_len),
        .addr       (axi_wr_addr)
    );

    burst_addr_gen rd_addr_gen (
        .clk        (clk),
        .rst_n_sync (rst_n_sync),
        .reload     (rd_rst),
        .done       (axi_rd_done),
        .beg_addr   (rd_beg_addr),
        .end_addr   (rd_end_addr),
        .burst_len  (rd_burst_len),
        .addr       (axi_rd_addr)
    );

endmodule

`default_nettype wire

//--- testbench/axi_burst_ctrl_assert.sv
`default_nettype none

// start request rules, watched inside burst_request
module axi_burst_ctrl_assert (
    input logic clk,
    input logic rst_n_sync,
    input logic axi_wr_ready,
    input logic axi_rd_ready,
    input logic axi_wr_start,
    input logic axi_rd_start
);
    timeunit 1ns;
    timeprecision 1ns;

    int unsigned fail_cnt = 0;  // failed rule checks so far

    ////////////////////////////////////////////////////////////
    // reset
    ////////////////////////////////////////////////////////////
    start_low_after_reset: assert property (@(posedge clk)
        $rose(rst_n_sync) |=> (!axi_wr_start && !axi_rd_start))
        else begin
            $error("start request high in the cycle after reset");
            fail_cnt++;
        end

    ////////////////////////////////////////////////////////////
    // request follows master ready
    ////////////////////////////////////////////////////////////
    wr_start_drops: assert property (@(posedge clk) disable iff (!rst_n_sync)
        !axi_wr_ready |=> !axi_wr_start)
        else begin
            $error("axi_wr_start still high a cycle after ready went low");
            fail_cnt++;
        end

    rd_start_drops: assert property (@(posedge clk) disable iff (!rst_n_sync)
        !axi_rd_ready |=> !axi_rd_start)
        else begin
            $error("axi_rd_start still high a cycle after ready went low");
            fail_cnt++;
        end

    wr_start_rise_ready: assert property (@(posedge clk) disable iff (!rst_n_sync)
        $rose(axi_wr_start) |-> $past(axi_wr_ready))
        else begin
            $error("axi_wr_start rose while the write master was busy");
            fail_cnt++;
        end

    rd_start_rise_ready: assert property (@(posedge clk) disable iff (!rst_n_sync)
        $rose(axi_rd_start) |-> $past(axi_rd_ready))
        else begin
            $error("axi_rd_start rose while the read master was busy");
            fail_cnt++;
        end

endmodule

bind burst_request axi_burst_ctrl_assert u_start_checks (
    .clk          (clk),
    .rst_n_sync   (rst_n_sync),
    .axi_wr_ready (axi_wr_ready),
    .axi_rd_ready (axi_rd_ready),
    .axi_wr_start (axi_wr_start),
    .axi_rd_start (axi_rd_start)
);

`default_nettype wire

//--- testbench/axi_burst_ctrl_tb.sv
`default_nettype none

`include "burst_ctrl_settings.svh"

// directed testbench for the burst controller with a behavioral axi master
module axi_burst_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ns;

    import burst_ctrl_pkg::*;

    logic       clk = 1'b0;
    logic       rst_n_sync;
    logic       wr_rst, rd_rst, wr_en, rd_mem_enable, rd_en, rd_valid;
    user_word_t wr_data, rd_data;
    mem_addr_t  wr_beg_addr, wr_end_addr, rd_beg_addr, rd_end_addr;
    burst_len_t wr_burst_len, rd_burst_len, axi_wr_len, axi_rd_len;
    logic       axi_writing, axi_wr_ready, axi_wr_done, axi_wr_start;
    logic       axi_reading, axi_rd_ready, axi_rd_done, axi_rd_start;
    axi_word_t  axi_wr_data, axi_rd_data;
    mem_addr_t  axi_wr_addr, axi_rd_addr;

    integer     seed;
    int         errors;
    int         checks;
    axi_word_t  wr_exp_q[$];   // packed beats the write master must see
    user_word_t rd_exp_q[$];   // user words the read port must yield
    mem_addr_t  wr_exp_addr;   // address model, write side
    mem_addr_t  rd_exp_addr;   // address model, read side

    axi_burst_ctrl dut (.*);

    initial begin
        forever #10 clk = ~clk;  // 20 ns period
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    // window rule: wrap once another burst after this one would pass the end
    function automatic mem_addr_t next_addr(input mem_addr_t cur, input mem_addr_t beg,
                                            input mem_addr_t last, input burst_len_t len);
        mem_addr_t step;
        mem_addr_t limit;
        step  = (mem_addr_t'(len) + mem_addr_t'(1)) * mem_addr_t'(`BC_BYTES_PER_BEAT);
        limit = last + mem_addr_t'(1) - step - step;
        if (cur > limit) begin
            return beg;
        end
        return cur + step;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int first_err);
        $display("test %s done with %0d errors", name, errors - first_err);
    endtask

    task automatic write_words(input int n);  // n is even, packer starts a pair
        user_word_t w;
        user_word_t first;
        int         i;
        for (i = 0; i < n; i++) begin
            w       = $random(seed);
            wr_en   = 1'b1;
            wr_data = w;
            if (i % 2 == 0) begin
                first = w;                       // low half of the beat
            end else begin
                wr_exp_q.push_back({w, first});  // later word high
            end
            @(negedge clk);
        end
        wr_en = 1'b0;
    endtask

    task automatic wait_wr_start(output bit ok);
        int n;
        n = 0;
        while (!axi_wr_start && n < 200) begin
            @(negedge clk);
            n++;
        end
        ok = axi_wr_start;
        if (!ok) begin
            $display("Timeout: axi_wr_start did not rise within 200 cycles");
            errors++;
        end
    endtask

    task automatic wait_rd_start(output bit ok);
        int n;
        n = 0;
        while (!axi_rd_start && n < 200) begin
            @(negedge clk);
            n++;
        end
        ok = axi_rd_start;
        if (!ok) begin
            $display("Timeout: axi_rd_start did not rise within 200 cycles");
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // axi master model
    ////////////////////////////////////////////////////////////
    task automatic run_wr_burst;
        axi_word_t exp;
        int        i;
        check_value("axi_wr_addr at burst start", axi_wr_addr, wr_exp_addr);
        axi_wr_ready = 1'b0;  // master busy, start must drop
        for (i = 0; i <= int'(wr_burst_len); i++) begin
            axi_writing = 1'b1;
            exp = (wr_exp_q.size() > 0) ? wr_exp_q.pop_front() : '0;
            check_value("axi_wr_data", axi_wr_data, exp);  // head before pop edge
            @(negedge clk);
        end
        axi_writing = 1'b0;
        axi_wr_done = 1'b1;
        @(negedge clk);
        axi_wr_done  = 1'b0;
        axi_wr_ready = 1'b1;
        wr_exp_addr  = next_addr(wr_exp_addr, wr_beg_addr, wr_end_addr, wr_burst_len);
        check_value("axi_wr_addr after done", axi_wr_addr, wr_exp_addr);
    endtask

    task automatic run_rd_burst;
        axi_word_t beat;
        int        i;
        check_value("axi_rd_addr at burst start", axi_rd_addr, rd_exp_addr);
        axi_rd_ready = 1'b0;
        for (i = 0; i <= int'(rd_burst_len); i++) begin
            beat        = {$random(seed), $random(seed)};
            axi_reading = 1'b1;
            axi_rd_data = beat;
            rd_exp_q.push_back(beat[`BC_USER_WIDTH-1:0]);  // low half first
            rd_exp_q.push_back(beat[`BC_AXI_WIDTH-1:`BC_USER_WIDTH]);
            @(negedge clk);
        end
        axi_reading = 1'b0;
        axi_rd_done = 1'b1;
        @(negedge clk);
        axi_rd_done  = 1'b0;
        axi_rd_ready = 1'b1;
        rd_exp_addr  = next_addr(rd_exp_addr, rd_beg_addr, rd_end_addr, rd_burst_len);
        check_value("axi_rd_addr after done", axi_rd_addr, rd_exp_addr);
    endtask

    task automatic read_user_words;
        user_word_t exp;
        int         n;
        while (rd_exp_q.size() > 0) begin
            exp = rd_exp_q.pop_front();
            n   = 0;
            while (!rd_valid && n < 50) begin
                @(negedge clk);
                n++;
            end
            if (!rd_valid) begin
                $display("Timeout: rd_valid stayed low, %0d user words never arrived",
                         rd_exp_q.size() + 1);
                errors++;
                rd_exp_q.delete();
            end else begin
                check_value("rd_data", rd_data, exp);
                rd_en = 1'b1;  // consume this half
                @(negedge clk);
                rd_en = 1'b0;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset_values;
        int first_err;
        first_err = errors;
        check_value("axi_wr_start", axi_wr_start, 0);
        check_value("axi_rd_start", axi_rd_start, 0);
        check_value("rd_valid", rd_valid, 0);
        check_value("axi_wr_addr", axi_wr_addr, wr_beg_addr);
        check_value("axi_rd_addr", axi_rd_addr, rd_beg_addr);
        check_value("axi_wr_len", axi_wr_len, wr_burst_len);  // plain pass-through
        check_value("axi_rd_len", axi_rd_len, rd_burst_len);
        report_test("reset_values", first_err);
    endtask

    task automatic test_write_packing;
        int first_err;
        bit ok;
        first_err = errors;
        write_words(2 * (int'(wr_burst_len) + 2));  // one burst plus one beat
        wait_wr_start(ok);
        if (ok) begin
            run_wr_burst();
        end
        report_test("write_packing", first_err);
    endtask

    task automatic test_write_addr;
        int first_err;
        int k;
        bit ok;
        first_err = errors;
        for (k = 0; k < 4; k++) begin  // enough bursts to pass the wrap
            write_words(2 * (int'(wr_burst_len) + 1));
            wait_wr_start(ok);
            if (ok) begin
                run_wr_burst();
            end
        end
        wr_rst = 1'b1;
        @(negedge clk);
        wr_rst      = 1'b0;
        wr_exp_addr = wr_beg_addr;
        check_value("axi_wr_addr after wr_rst", axi_wr_addr, wr_exp_addr);
        report_test("write_addr", first_err);
    endtask

    task automatic test_read_path;
        int first_err;
        bit ok;
        first_err     = errors;
        rd_mem_enable = 1'b1;
        wait_rd_start(ok);
        rd_mem_enable = 1'b0;  // one burst only
        if (ok) begin
            run_rd_burst();
            read_user_words();
        end
        report_test("read_path", first_err);
    endtask

    task automatic test_read_withheld;
        int first_err;
        int i;
        first_err     = errors;
        rd_mem_enable = 1'b0;
        repeat (40) begin
            check_value("axi_rd_start with reads disabled", axi_rd_start, 0);
            @(negedge clk);
        end
        for (i = 0; i < `BC_RD_LOW_WATER + 2; i++) begin  // fill past low water
            axi_reading = 1'b1;
            axi_rd_data = {$random(seed), $random(seed)};
            @(negedge clk);
        end
        axi_reading   = 1'b0;
        rd_mem_enable = 1'b1;
        repeat (20) begin
            check_value("axi_rd_start above low water", axi_rd_start, 0);
            @(negedge clk);
        end
        rd_mem_enable = 1'b0;
        rd_rst        = 1'b1;
        @(negedge clk);
        rd_rst      = 1'b0;
        rd_exp_addr = rd_beg_addr;
        check_value("axi_rd_addr after rd_rst", axi_rd_addr, rd_exp_addr);
        report_test("read_withheld", first_err);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        seed          = 32'h9601_c431;
        errors        = 0;
        checks        = 0;
        rst_n_sync    = 1'b0;
        wr_rst        = 1'b0;
        rd_rst        = 1'b0;
        wr_en         = 1'b0;
        wr_data       = '0;
        rd_mem_enable = 1'b0;
        rd_en         = 1'b0;
        wr_beg_addr   = 30'h0000_1000;
        wr_end_addr   = 30'h0000_107f;  // small window, wraps after a few bursts
        rd_beg_addr   = 30'h0000_2000;
        rd_end_addr   = 30'h0000_2fff;
        wr_burst_len  = 8'd3;
        rd_burst_len  = 8'd3;
        axi_writing   = 1'b0;
        axi_wr_ready  = 1'b1;
        axi_wr_done   = 1'b0;
        axi_reading   = 1'b0;
        axi_rd_ready  = 1'b1;
        axi_rd_done   = 1'b0;
        axi_rd_data   = '0;
        repeat (2) @(negedge clk);
        rst_n_sync = 1'b1;
        @(negedge clk);
        wr_exp_addr = wr_beg_addr;
        rd_exp_addr = rd_beg_addr;

        test_reset_values();
        test_write_packing();
        test_write_addr();
        test_read_path();
        test_read_withheld();

        // start request rules watched inside burst_request
        errors += int'(dut.u_burst_request.u_start_checks.fail_cnt);

        $display("tests run: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/burst_ctrl_pkg.sv
rtl/burst_fifo.sv
rtl/word_packer.sv
rtl/word_unpacker.sv
rtl/burst_addr_gen.sv
rtl/burst_request.sv
rtl/axi_burst_ctrl.sv
testbench/axi_burst_ctrl_assert.sv
testbench/axi_burst_ctrl_tb.sv

//--- Makefile
TOP := axi_burst_ctrl_tb
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f src.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
